// ==== ascon_defines.svh ====
// Ascon constants for SP 800-232 hashing only; rate and word width are fixed at 64 bits

`ifndef ASCON_DEFINES_SVH
`define ASCON_DEFINES_SVH

// ------------------------------
// Permutation and sponge geometry
// ------------------------------

// Rounds per permutation call, p12 only
`define ASCON_ROUNDS        12

// Rate in bits, equal to one state word
`define ASCON_RATE_BITS     64

// Hash256 digest length in 64-bit words
`define ASCON_HASH_WORDS    4

// Initial values placed in state word 0
`define ASCON_IV_HASH256    64'h0000_0801_00cc_0002
`define ASCON_IV_XOF128     64'h0000_0800_00cc_0003

// Width of the requested XOF output word count
`define ASCON_XOF_LEN_BITS  16

`endif

// ==== ascon_pkg.sv ====
// Shared Ascon types; words are little-endian with byte 0 in bits 7:0

package ascon_pkg;

    `include "ascon_defines.svh"

    // ------------------------------
    // Data types
    // ------------------------------

    // One rate word or one state word
    typedef logic [`ASCON_RATE_BITS-1:0] ascon_word_t;

    // Full 320-bit state, index 0 is the rate word
    typedef ascon_word_t [4:0] ascon_state_t;

    // Byte enables of one stream beat
    typedef logic [(`ASCON_RATE_BITS/8)-1:0] ascon_keep_t;

    // Output word count for XOF128
    typedef logic [`ASCON_XOF_LEN_BITS-1:0] ascon_len_t;

    // Round index within p12
    typedef logic [3:0] ascon_round_t;

    // ------------------------------
    // Operating modes
    // ------------------------------
    typedef enum logic {
        MODE_HASH256 = 1'b0,
        MODE_XOF128  = 1'b1
    } ascon_mode_e;

endpackage

// ==== ascon_block_if.sv ====
// Padded rate blocks; block and last_block must hold while valid is high and ready low
`timescale 1ns/1ps

interface ascon_block_if;
    import ascon_pkg::*;

    ascon_word_t block;       // Padded 64-bit rate block
    logic        last_block;  // Final block of the message
    logic        valid;
    logic        ready;

    // Padder produces blocks
    modport padder (output block, output last_block, output valid, input ready);
    // Controller owns the handshake
    modport sink   (input valid, input last_block, output ready);
    // Core only samples the data
    modport core   (input block);

endinterface

// ==== ascon_core_if.sv ====
// Controller to core commands; a command is only acted on while perm_busy is low
`timescale 1ns/1ps

interface ascon_core_if;
    import ascon_pkg::*;

    logic        load_iv;     // State becomes IV followed by zeros
    ascon_word_t iv;
    logic        absorb;      // XOR block into state word 0
    logic        start_perm;  // Begin 12 rounds next cycle
    logic        perm_busy;   // High for exactly 12 cycles per call
    ascon_word_t rate_word;   // Always state word 0

    // ------------------------------
    // Views of the link
    // ------------------------------
    modport ctrl   (output load_iv, output iv, output absorb, output start_perm,
                    input perm_busy);
    modport core   (input load_iv, input iv, input absorb, input start_perm,
                    output perm_busy, output rate_word);
    // Squeeze side only reads the rate word
    modport reader (input rate_word);

endinterface

// ==== ascon_round.sv ====
// One combinational Ascon round for p12; round_idx_i must lie in 0..11
`timescale 1ns/1ps

module ascon_round (
    input  ascon_pkg::ascon_state_t state_i,
    input  ascon_pkg::ascon_round_t round_idx_i,
    output ascon_pkg::ascon_state_t state_o
);

    // Rotate right by a fixed amount
    function automatic logic [63:0] ror(input logic [63:0] v, input int n);
        return (v >> n) | (v << (64 - n));
    endfunction

    logic [63:0] x0, x1, x2, x3, x4;
    logic [63:0] t0, t1, t2, t3, t4;
    logic [7:0]  rc;

    // Constant for p12: high nibble 0xf-i, low nibble i
    assign rc = {4'hf - round_idx_i, round_idx_i};

    always_comb begin
        x0 = state_i[0];
        x1 = state_i[1];
        x2 = state_i[2] ^ {56'd0, rc};
        x3 = state_i[3];
        x4 = state_i[4];

        // ------------------------------
        // Substitution layer, bit-sliced
        // ------------------------------
        x0 = x0 ^ x4;
        x4 = x4 ^ x3;
        x2 = x2 ^ x1;
        t0 = ~x0 & x1;
        t1 = ~x1 & x2;
        t2 = ~x2 & x3;
        t3 = ~x3 & x4;
        t4 = ~x4 & x0;
        x0 = x0 ^ t1;
        x1 = x1 ^ t2;
        x2 = x2 ^ t3;
        x3 = x3 ^ t4;
        x4 = x4 ^ t0;
        x1 = x1 ^ x0;
        x0 = x0 ^ x4;
        x3 = x3 ^ x2;
        x2 = ~x2;

        // ------------------------------
        // Linear diffusion per word
        // ------------------------------
        state_o[0] = x0 ^ ror(x0, 19) ^ ror(x0, 28);
        state_o[1] = x1 ^ ror(x1, 61) ^ ror(x1, 39);
        state_o[2] = x2 ^ ror(x2, 1)  ^ ror(x2, 6);
        state_o[3] = x3 ^ ror(x3, 10) ^ ror(x3, 17);
        state_o[4] = x4 ^ ror(x4, 7)  ^ ror(x4, 41);
    end

endmodule

// ==== ascon_padder.sv ====
// Input padder; assumes tkeep is contiguous from byte 0 and full on every non-final beat
`timescale 1ns/1ps

module ascon_padder (
    input  logic                   clk,
    input  logic                   rst_n_i,

    // Raw message stream
    input  ascon_pkg::ascon_word_t s_axis_tdata_i,
    input  ascon_pkg::ascon_keep_t s_axis_tkeep_i,
    input  logic                   s_axis_tlast_i,
    input  logic                   s_axis_tvalid_i,
    output logic                   s_axis_tready_o,

    // Padded blocks towards the core
    ascon_block_if.padder          blk
);
    import ascon_pkg::*;

    ascon_word_t padded_word;  // Raw word with pad byte inserted
    logic        final_full;   // Last beat carries all 8 bytes
    logic        pend_q;       // Extra pad-only block still owed
    logic        raw_xfer;     // Raw beat accepted this cycle

    // ------------------------------
    // Pad byte placement
    // ------------------------------
    always_comb begin
        for (int b = 0; b < 8; b++) begin
            if (s_axis_tkeep_i[b]) begin
                padded_word[8*b +: 8] = s_axis_tdata_i[8*b +: 8];
            end else if (s_axis_tlast_i && (b == 0 || s_axis_tkeep_i[(b == 0) ? 0 : b-1])) begin
                // First empty byte after the message
                padded_word[8*b +: 8] = 8'h01;
            end else begin
                padded_word[8*b +: 8] = 8'h00;
            end
        end
    end

    assign final_full = s_axis_tlast_i && (s_axis_tkeep_i == '1);

    // ------------------------------
    // Block output and handshake
    // ------------------------------
    always_comb begin
        if (pend_q) begin
            // Pad byte alone in byte 0, raw stream held off
            blk.block       = ascon_word_t'(8'h01);
            blk.last_block  = 1'b1;
            blk.valid       = 1'b1;
            s_axis_tready_o = 1'b0;
        end else begin
            blk.block       = padded_word;
            // A full final word is not yet the last block
            blk.last_block  = s_axis_tlast_i && !final_full;
            blk.valid       = s_axis_tvalid_i;
            s_axis_tready_o = blk.ready;
        end
    end

    assign raw_xfer = s_axis_tvalid_i && s_axis_tready_o;

    // Pending flag for the extra pad block
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pend_q <= 1'b0;
        end else if (pend_q) begin
            if (blk.ready) begin
                pend_q <= 1'b0;
            end
        end else if (raw_xfer && final_full) begin
            pend_q <= 1'b1;
        end
    end

endmodule

// ==== ascon_core.sv ====
// Permutation core; load_iv, absorb and start_perm are ignored while a permutation runs
`timescale 1ns/1ps
`include "ascon_defines.svh"

module ascon_core (
    input  logic       clk,
    input  logic       rst_n_i,
    ascon_core_if.core cmd,
    ascon_block_if.core blk
);
    import ascon_pkg::*;

    ascon_state_t state_q;    // Sponge state, word 0 is the rate
    ascon_state_t round_out;  // State after one round
    ascon_round_t rnd_q;      // Current round index
    logic         busy_q;

    ascon_round u_round (
        .state_i     (state_q),
        .round_idx_i (rnd_q),
        .state_o     (round_out)
    );

    // ------------------------------
    // Round sequencing
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            rnd_q  <= '0;
        end else if (busy_q) begin
            rnd_q <= rnd_q + 1'b1;
            if (rnd_q == ascon_round_t'(`ASCON_ROUNDS - 1)) begin
                busy_q <= 1'b0;
            end
        end else if (cmd.start_perm) begin
            // Rounds begin on the state written this same edge
            busy_q <= 1'b1;
            rnd_q  <= '0;
        end
    end

    // ------------------------------
    // State register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (busy_q) begin
            state_q <= round_out;
        end else if (cmd.load_iv) begin
            state_q    <= '0;
            state_q[0] <= cmd.iv;
        end else if (cmd.absorb) begin
            // Rate absorb into word 0 only
            state_q[0] <= state_q[0] ^ blk.block;
        end
    end

    assign cmd.perm_busy = busy_q;
    assign cmd.rate_word = state_q[0];

endmodule

// ==== ascon_hash_ctrl.sv ====
// Sponge controller; start_i is honoured only in idle and the mode is held for the whole run
`timescale 1ns/1ps
`include "ascon_defines.svh"

module ascon_hash_ctrl (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   start_i,
    input  ascon_pkg::ascon_mode_e mode_i,
    output logic                   busy_o,
    output logic                   done_o,
    ascon_core_if.ctrl             cmd,
    ascon_block_if.sink            blk,
    output logic                   sq_load_o,
    input  logic                   sq_taken_i,
    input  logic                   sq_final_i
);
    import ascon_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_INIT_PERM,
        S_ABS_WAIT,
        S_ABS_PERM,
        S_FINAL_PERM,
        S_SQ_HOLD,
        S_SQ_PERM
    } ctrl_state_e;

    ctrl_state_e state_q, state_d;
    ascon_mode_e mode_q;
    logic        init_q;     // One-cycle IV load and first p12
    logic        done_q;
    logic        blk_xfer;   // Block absorbed this cycle
    logic        sq_next;    // Non-final word taken, squeeze again
    logic        perm_done;  // Core idle and no call pending

    assign blk_xfer  = (state_q == S_ABS_WAIT) && blk.valid;
    assign sq_next   = (state_q == S_SQ_HOLD) && sq_taken_i && !sq_final_i;
    assign perm_done = !cmd.perm_busy && !init_q;

    // ------------------------------
    // Next state
    // ------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:       if (start_i) state_d = S_INIT_PERM;
            S_INIT_PERM:  if (perm_done) state_d = S_ABS_WAIT;
            S_ABS_WAIT: begin
                if (blk.valid) begin
                    state_d = blk.last_block ? S_FINAL_PERM : S_ABS_PERM;
                end
            end
            S_ABS_PERM:   if (perm_done) state_d = S_ABS_WAIT;
            S_FINAL_PERM: if (perm_done) state_d = S_SQ_HOLD;
            S_SQ_HOLD: begin
                if (sq_taken_i) begin
                    state_d = sq_final_i ? S_IDLE : S_SQ_PERM;
                end
            end
            S_SQ_PERM:    if (perm_done) state_d = S_SQ_HOLD;
            default:      state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
            mode_q  <= MODE_HASH256;
            init_q  <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            init_q  <= (state_q == S_IDLE) && start_i;
            done_q  <= (state_q == S_SQ_HOLD) && sq_taken_i && sq_final_i;
            if ((state_q == S_IDLE) && start_i) begin
                mode_q <= mode_i;
            end
        end
    end

    // ------------------------------
    // Core commands
    // ------------------------------
    assign cmd.load_iv    = init_q;
    assign cmd.iv         = (mode_q == MODE_XOF128) ? `ASCON_IV_XOF128 : `ASCON_IV_HASH256;
    assign cmd.absorb     = blk_xfer;
    assign cmd.start_perm = init_q || blk_xfer || sq_next;

    // Ready only while waiting for a block
    assign blk.ready = (state_q == S_ABS_WAIT);

    // Capture the rate word once a final or squeeze p12 ends
    assign sq_load_o = ((state_q == S_FINAL_PERM) || (state_q == S_SQ_PERM)) && perm_done;

    assign busy_o = (state_q != S_IDLE);
    assign done_o = done_q;

endmodule

// ==== ascon_squeeze_out.sv ====
// Output stream; Hash256 gives 4 words, XOF128 gives xof_len_i words and 0 counts as 1
`timescale 1ns/1ps
`include "ascon_defines.svh"

module ascon_squeeze_out (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   start_i,
    input  ascon_pkg::ascon_mode_e mode_i,
    input  ascon_pkg::ascon_len_t  xof_len_i,
    ascon_core_if.reader           rd,
    input  logic                   sq_load_i,
    output logic                   sq_taken_o,
    output logic                   sq_final_o,
    output ascon_pkg::ascon_word_t m_axis_tdata_o,
    output logic                   m_axis_tlast_o,
    output logic                   m_axis_tvalid_o,
    input  logic                   m_axis_tready_i
);
    import ascon_pkg::*;

    ascon_len_t  start_len;  // Word count for a new run
    ascon_len_t  remain_q;   // Words not yet transferred
    ascon_word_t data_q;
    logic        active_q;   // Run in progress, blocks a new start
    logic        valid_q;
    logic        last_q;

    assign start_len = (mode_i == MODE_HASH256) ? ascon_len_t'(`ASCON_HASH_WORDS) :
                       ((xof_len_i == '0) ? ascon_len_t'(1) : xof_len_i);

    assign sq_taken_o = valid_q && m_axis_tready_i;
    assign sq_final_o = sq_taken_o && last_q;

    // ------------------------------
    // Counter and stream flags
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            active_q <= 1'b0;
            remain_q <= '0;
            valid_q  <= 1'b0;
            last_q   <= 1'b0;
        end else begin
            if (start_i && !active_q) begin
                active_q <= 1'b1;
                remain_q <= start_len;
            end
            if (sq_load_i) begin
                valid_q <= 1'b1;
                last_q  <= (remain_q == ascon_len_t'(1));
            end else if (sq_taken_o) begin
                valid_q  <= 1'b0;
                remain_q <= remain_q - 1'b1;
                if (last_q) active_q <= 1'b0;
            end
        end
    end

    // Output word, held until accepted
    always_ff @(posedge clk) begin
        if (sq_load_i) data_q <= rd.rate_word;
    end

    assign m_axis_tdata_o  = data_q;
    assign m_axis_tlast_o  = last_q;
    assign m_axis_tvalid_o = valid_q;

endmodule

// ==== ascon_hash_top.sv ====
// Ascon Hash256 and XOF128 accelerator; mode_i and xof_len_i are sampled with start_i only
`timescale 1ns/1ps

module ascon_hash_top (
    input  logic                   clk,
    input  logic                   rst_n_i,

    // Control and status
    input  ascon_pkg::ascon_mode_e mode_i,
    input  logic                   start_i,
    input  ascon_pkg::ascon_len_t  xof_len_i,
    output logic                   busy_o,
    output logic                   done_o,

    // ------------------------------
    // Message input stream
    // ------------------------------
    input  ascon_pkg::ascon_word_t s_axis_tdata_i,
    input  ascon_pkg::ascon_keep_t s_axis_tkeep_i,
    input  logic                   s_axis_tlast_i,
    input  logic                   s_axis_tvalid_i,
    output logic                   s_axis_tready_o,

    // ------------------------------
    // Digest output stream
    // ------------------------------
    output ascon_pkg::ascon_word_t m_axis_tdata_o,
    output logic                   m_axis_tlast_o,
    output logic                   m_axis_tvalid_o,
    input  logic                   m_axis_tready_i
);

    ascon_block_if blk_if ();
    ascon_core_if  core_if ();

    // Squeeze handshake between controller and output side
    logic sq_load;
    logic sq_taken;
    logic sq_final;

    ascon_padder u_padder (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .s_axis_tdata_i  (s_axis_tdata_i),
        .s_axis_tkeep_i  (s_axis_tkeep_i),
        .s_axis_tlast_i  (s_axis_tlast_i),
        .s_axis_tvalid_i (s_axis_tvalid_i),
        .s_axis_tready_o (s_axis_tready_o),
        .blk             (blk_if.padder)
    );

    ascon_core u_core (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .cmd     (core_if.core),
        .blk     (blk_if.core)
    );

    ascon_hash_ctrl u_ctrl (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .start_i    (start_i),
        .mode_i     (mode_i),
        .busy_o     (busy_o),
        .done_o     (done_o),
        .cmd        (core_if.ctrl),
        .blk        (blk_if.sink),
        .sq_load_o  (sq_load),
        .sq_taken_i (sq_taken),
        .sq_final_i (sq_final)
    );

    ascon_squeeze_out u_squeeze (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .start_i         (start_i),
        .mode_i          (mode_i),
        .xof_len_i       (xof_len_i),
        .rd              (core_if.reader),
        .sq_load_i       (sq_load),
        .sq_taken_o      (sq_taken),
        .sq_final_o      (sq_final),
        .m_axis_tdata_o  (m_axis_tdata_o),
        .m_axis_tlast_o  (m_axis_tlast_o),
        .m_axis_tvalid_o (m_axis_tvalid_o),
        .m_axis_tready_i (m_axis_tready_i)
    );

endmodule

// ==== tb_ascon_hash_top.sv ====
// Trace-driven testbench; run from the project root so that ascon_trace.txt is found
`timescale 1ns/1ps

module tb_ascon_hash_top;
    import ascon_pkg::*;

    localparam int TRACE_DEPTH = 256;

    logic        clk;
    logic        rst_n_i;
    ascon_mode_e mode_i;
    logic        start_i;
    ascon_len_t  xof_len_i;
    logic        busy_o;
    logic        done_o;
    ascon_word_t s_axis_tdata_i;
    ascon_keep_t s_axis_tkeep_i;
    logic        s_axis_tlast_i;
    logic        s_axis_tvalid_i;
    logic        s_axis_tready_o;
    ascon_word_t m_axis_tdata_o;
    logic        m_axis_tlast_o;
    logic        m_axis_tvalid_o;
    logic        m_axis_tready_i;

    logic [63:0] trace_mem [0:TRACE_DEPTH-1];
    int          trace_ptr;     // Next unread trace entry
    int          limit_cycles;  // Watchdog budget
    logic        trace_ready;

    ascon_hash_top ascon_hash_top_i (.*);

    // ------------------------------
    // Clock and watchdog
    // ------------------------------
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        wait (trace_ready);
        repeat (limit_cycles) @(posedge clk);
        stop_with_error("timeout: the DUT did not finish the trace in time");
    end

    // ------------------------------
    // Failure reporting and compares
    // ------------------------------
    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "run aborted");
    endtask

    task automatic check_word(input string name, input ascon_word_t got, input ascon_word_t exp);
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
            $display("** FAIL **");
            $fatal(1, "run aborted");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s got %b expected %b", $time, name, got, exp);
            $display("** FAIL **");
            $fatal(1, "run aborted");
        end
    endtask

    // Word count by mode: 4 for Hash256, xof_len for XOF128 with 0 read as 1
    function automatic int expected_count(input ascon_mode_e mode, input ascon_len_t len);
        if (mode == MODE_HASH256) return 4;
        if (len == '0) return 1;
        return int'(len);
    endfunction

    // ------------------------------
    // Stream drivers
    // ------------------------------
    task automatic send_message(input int base, input int n_in);
        int gap;
        for (int i = 0; i < n_in; i++) begin
            gap = $urandom_range(0, 2);
            repeat (gap) begin
                @(negedge clk);
                s_axis_tvalid_i = 1'b0;
            end
            @(negedge clk);
            s_axis_tvalid_i = 1'b1;
            s_axis_tdata_i  = trace_mem[base + 2*i + 1];
            s_axis_tkeep_i  = trace_mem[base + 2*i][7:0];
            s_axis_tlast_i  = trace_mem[base + 2*i][8];
            // Beat moves on the posedge after a negedge with ready high
            while (!s_axis_tready_o) @(negedge clk);
        end
        @(negedge clk);
        s_axis_tvalid_i = 1'b0;
        s_axis_tlast_i  = 1'b0;
        s_axis_tkeep_i  = '0;
        s_axis_tdata_i  = '0;
    endtask

    task automatic collect_output(input int base, input int n_out);
        int          got;
        logic        stalled;    // Valid seen without ready last cycle
        ascon_word_t held_data;
        logic        held_last;
        got     = 0;
        stalled = 1'b0;
        while (got < n_out) begin
            @(negedge clk);
            check_flag("done_o", done_o, 1'b0);
            if (stalled) begin
                // Output must hold under back-pressure
                check_flag("m_axis_tvalid_o", m_axis_tvalid_o, 1'b1);
                check_word("m_axis_tdata_o", m_axis_tdata_o, held_data);
                check_flag("m_axis_tlast_o", m_axis_tlast_o, held_last);
            end
            m_axis_tready_i = ($urandom_range(0, 3) != 0);
            if (m_axis_tvalid_o && m_axis_tready_i) begin
                check_word("m_axis_tdata_o", m_axis_tdata_o, trace_mem[base + got]);
                check_flag("m_axis_tlast_o", m_axis_tlast_o, got == n_out - 1);
                got++;
                stalled = 1'b0;
            end else begin
                stalled   = m_axis_tvalid_o;
                held_data = m_axis_tdata_o;
                held_last = m_axis_tlast_o;
            end
        end
        // Cycle after the tlast transfer
        @(negedge clk);
        m_axis_tready_i = 1'b0;
        check_flag("done_o", done_o, 1'b1);
        check_flag("busy_o", busy_o, 1'b0);
        check_flag("m_axis_tvalid_o", m_axis_tvalid_o, 1'b0);
        @(negedge clk);
        check_flag("done_o", done_o, 1'b0);
    endtask

    task automatic run_case(input int case_no);
        ascon_mode_e mode;
        ascon_len_t  len;
        int          n_in;
        int          n_out;
        int          in_base;
        int          out_base;
        mode      = trace_mem[trace_ptr][0] ? MODE_XOF128 : MODE_HASH256;
        len       = trace_mem[trace_ptr + 1][15:0];
        n_in      = int'(trace_mem[trace_ptr + 2]);
        n_out     = int'(trace_mem[trace_ptr + 3]);
        in_base   = trace_ptr + 4;
        out_base  = in_base + 2*n_in;
        trace_ptr = out_base + n_out;
        if (n_out != expected_count(mode, len)) begin
            stop_with_error($sformatf("trace case %0d lists %0d output words, mode needs %0d",
                                      case_no, n_out, expected_count(mode, len)));
        end
        @(negedge clk);
        mode_i    = mode;
        xof_len_i = len;
        start_i   = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
        check_flag("busy_o", busy_o, 1'b1);
        fork
            send_message(in_base, n_in);
            collect_output(out_base, n_out);
        join
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        int unsigned seed_init;
        int          n_cases;
        int          total_words;
        int          p;
        seed_init       = $urandom(33430);
        trace_ready     = 1'b0;
        rst_n_i         = 1'b0;
        start_i         = 1'b0;
        mode_i          = MODE_HASH256;
        xof_len_i       = '0;
        s_axis_tdata_i  = '0;
        s_axis_tkeep_i  = '0;
        s_axis_tlast_i  = 1'b0;
        s_axis_tvalid_i = 1'b0;
        m_axis_tready_i = 1'b0;
        for (int i = 0; i < TRACE_DEPTH; i++) trace_mem[i] = '0;
        $readmemh("ascon_trace.txt", trace_mem);
        n_cases = int'(trace_mem[0]);
        if (n_cases == 0) stop_with_error("trace file is missing or holds no cases");

        // Budget of 12 cycles per word plus room for gaps and stalls
        total_words = 0;
        p = 1;
        for (int c = 0; c < n_cases; c++) begin
            total_words += int'(trace_mem[p + 2]) + int'(trace_mem[p + 3]);
            p += 4 + 2*int'(trace_mem[p + 2]) + int'(trace_mem[p + 3]);
        end
        limit_cycles = 100 + total_words * 12 + total_words * 16 + n_cases * 40;
        trace_ready  = 1'b1;

        repeat (8) @(negedge clk);
        rst_n_i = 1'b1;
        @(negedge clk);
        check_flag("busy_o", busy_o, 1'b0);
        check_flag("done_o", done_o, 1'b0);
        check_flag("s_axis_tready_o", s_axis_tready_o, 1'b0);
        check_flag("m_axis_tvalid_o", m_axis_tvalid_o, 1'b0);

        trace_ptr = 1;
        for (int c = 0; c < n_cases; c++) run_case(c);

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== ascon_trace.txt ====
// Per case: mode xof_len n_in n_out, then n_in pairs of {last,keep} and data,
// then n_out expected output words; the first value is the number of cases
6
// Hash256, empty message
0 0 1 4
100 0000000000000000
986b2f0f85e53b0b 649ba8de8f9ff2ca
838f9b24aa70faa1 b2924d30aa3bd59b
// Hash256, single byte 00
0 0 1 4
101 0000000000000000
d23eaf3510622807 f900e9fdf63ba0bc
23eeb5e430536f45 80bc9102e7a1f6e7
// XOF128, empty message, one word
1 1 1 1
100 0000000000000000
398bf564615e3d47
// XOF128, empty message, seven words
1 7 1 7
100 0000000000000000
398bf564615e3d47 2ee48adbac4ad8df e08e3833ed1fd9c2 c6953299b3d960d9
fe133b5d5a8577ad 3a37888909e6d96a 66f1a8056d95d0f7
// XOF128, length 0 gives one word
1 0 1 1
100 0000000000000000
398bf564615e3d47
// Hash256 again after the XOF runs
0 0 1 4
100 0000000000000000
986b2f0f85e53b0b 649ba8de8f9ff2ca
838f9b24aa70faa1 b2924d30aa3bd59b

// ==== ascon_hash_top.f ====
+incdir+.
ascon_pkg.sv
ascon_block_if.sv
ascon_core_if.sv
ascon_round.sv
ascon_padder.sv
ascon_core.sv
ascon_hash_ctrl.sv
ascon_squeeze_out.sv
ascon_hash_top.sv
tb_ascon_hash_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the Ascon testbench with Verilator from the project root
verilator --binary --timing -Wno-fatal -f ascon_hash_top.f \
    --top-module tb_ascon_hash_top -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -F -x -q "** PASS **" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
